// File: hdl/life_cell_pipe.sv
/* Life rule pipeline
   Three-row window, per-column sums, nine-cell sums and rule per cell */
`include "life_params.svh"

module life_cell_pipe (
	input logic clk,
	input logic reset,
	// Advance the window by one row
	input logic shift,
	input life_pkg::cell_row_t row_in,
	// Next state of the centre row, three edges after its below row
	output life_pkg::cell_row_t row_next
);

	//////////////////////////////
	// Row window
	//////////////////////////////

	life_pkg::cell_row_t row_above;
	life_pkg::cell_row_t row_centre;
	life_pkg::cell_row_t row_below;

	// Newest row enters at the bottom
	always_ff @(posedge clk) begin
		if (reset) begin
			row_above <= '0;
			row_centre <= '0;
			row_below <= '0;
		end else if (shift) begin
			row_above <= row_centre;
			row_centre <= row_below;
			row_below <= row_in;
		end
	end

	//////////////////////////////
	// Column and block sums
	//////////////////////////////

	logic [`LIFE_WIDTH-1:0][1:0] col_sum;
	logic [`LIFE_WIDTH-1:0][1:0] col_sum_q;
	logic [`LIFE_WIDTH-1:0][3:0] nine_sum;
	logic [`LIFE_WIDTH-1:0][3:0] nine_sum_q;
	life_pkg::cell_row_t centre_d1;
	life_pkg::cell_row_t centre_d2;
	life_pkg::cell_row_t rule_out;

	for (genvar i = 0; i < `LIFE_WIDTH; i++) begin : g_cell
		// Neighbour columns, wrapping round the row ends
		localparam int LEFT = (i == 0) ? `LIFE_WIDTH - 1 : i - 1;
		localparam int RIGHT = (i == `LIFE_WIDTH - 1) ? 0 : i + 1;

		// Vertical count of three cells
		assign col_sum[i] = {1'b0, row_above[i]} + {1'b0, row_centre[i]} +
			{1'b0, row_below[i]};

		// 3x3 block count, the cell itself included
		assign nine_sum[i] = {2'b00, col_sum_q[LEFT]} + {2'b00, col_sum_q[i]} +
			{2'b00, col_sum_q[RIGHT]};

		// Birth on 3, survival on 4 with the cell alive
		assign rule_out[i] = (nine_sum_q[i] == 4'd3) ||
			((nine_sum_q[i] == 4'd4) && centre_d2[i]);
	end

	// Stage 1, column sums
	// Centre row follows along for the rule
	always_ff @(posedge clk) begin
		col_sum_q <= col_sum;
		centre_d1 <= row_centre;
	end

	// Stage 2, block sums
	always_ff @(posedge clk) begin
		nine_sum_q <= nine_sum;
		centre_d2 <= centre_d1;
	end

	// Stage 3, new cell states
	always_ff @(posedge clk) begin
		row_next <= rule_out;
	end

endmodule

// File: hdl/life_core.sv
/* Life engine top level
   Row store, cell pipe and sequencer on one clock */
module life_core (
	input logic clk,
	input logic reset,
	// Host commands
	input logic init_start,
	input logic step,
	input logic wr_en,
	input life_pkg::row_addr_t wr_row,
	input life_pkg::cell_row_t wr_data,
	input logic rd_req,
	input life_pkg::row_addr_t rd_row,
	// Host status and readout
	output logic busy,
	output logic rd_valid,
	output life_pkg::cell_row_t rd_data,
	output life_pkg::gen_count_t gen_count
);

	// Store control from the sequencer
	logic rd_bank;
	life_pkg::row_addr_t rd_addr;
	logic we;
	logic wr_bank;
	life_pkg::row_addr_t wr_addr;
	life_pkg::cell_row_t mem_wdata;
	logic ld;
	logic shift;

	// Data paths
	life_pkg::cell_row_t mem_rdata;
	life_pkg::cell_row_t row_next;

	life_row_store u_store (
		.clk(clk),
		.rd_bank(rd_bank),
		.rd_addr(rd_addr),
		.we(we),
		.wr_bank(wr_bank),
		.wr_addr(wr_addr),
		.wr_data(mem_wdata),
		.ld(ld),
		.rd_data(mem_rdata),
		.dout(rd_data)
	);

	life_cell_pipe u_pipe (
		.clk(clk),
		.reset(reset),
		.shift(shift),
		.row_in(mem_rdata),
		.row_next(row_next)
	);

	life_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.init_start(init_start),
		.step(step),
		.wr_en(wr_en),
		.wr_row(wr_row),
		.wr_data(wr_data),
		.rd_req(rd_req),
		.rd_row(rd_row),
		.row_next(row_next),
		.busy(busy),
		.rd_valid(rd_valid),
		.gen_count(gen_count),
		.rd_bank(rd_bank),
		.rd_addr(rd_addr),
		.we(we),
		.wr_bank(wr_bank),
		.wr_addr(wr_addr),
		.mem_wdata(mem_wdata),
		.ld(ld),
		.shift(shift)
	);

endmodule

// File: hdl/life_params.svh
/* Life engine sizing
   Grid geometry, pipeline latency and LFSR fill constants */
`ifndef LIFE_PARAMS_SVH
`define LIFE_PARAMS_SVH

//////////////////////////////
// Grid geometry
//////////////////////////////

// Cells per row, one row per memory word
`define LIFE_WIDTH 32
// Rows per grid, power of two so row indices wrap for free
`define LIFE_DEPTH 32
`define LIFE_ROW_BITS $clog2(`LIFE_DEPTH)

// Generation counter width
`define LIFE_GEN_BITS 48

// Sweep read data to registered result row
`define LIFE_PIPE_LAT 4

// Fill LFSR, second feedback tap and reset value
`define LIFE_LFSR_TAP 1
`define LIFE_LFSR_SEED 1

`endif

// File: hdl/life_pkg.sv
/* Life engine shared types
   Row, address and counter types plus the sequencer states */
`include "life_params.svh"

package life_pkg;

	//////////////////////////////
	// Data and index types
	//////////////////////////////

	// One row of cells, bit i is column i
	typedef logic [`LIFE_WIDTH-1:0] cell_row_t;

	// Row index within one bank
	typedef logic [`LIFE_ROW_BITS-1:0] row_addr_t;

	// Generations since the last fill
	typedef logic [`LIFE_GEN_BITS-1:0] gen_count_t;

	//////////////////////////////
	// Sequencer
	//////////////////////////////

	// IDLE accepts host commands
	// FILL writes LFSR rows, SWEEP reads the grid, DRAIN empties the pipe
	typedef enum logic [1:0] {
		IDLE,
		FILL,
		SWEEP,
		DRAIN
	} seq_state_e;

endpackage

// File: hdl/life_row_store.sv
/* Two-bank row memory
   One write port, one registered read port, host readout latch */
`include "life_params.svh"

module life_row_store (
	input logic clk,
	// Read port
	input logic rd_bank,
	input life_pkg::row_addr_t rd_addr,
	// Write port
	input logic we,
	input logic wr_bank,
	input life_pkg::row_addr_t wr_addr,
	input life_pkg::cell_row_t wr_data,
	// Readout latch strobe
	input logic ld,
	output life_pkg::cell_row_t rd_data,
	output life_pkg::cell_row_t dout
);

	//////////////////////////////
	// Storage
	//////////////////////////////

	// Bank select is the top address bit
	life_pkg::cell_row_t ram [2*`LIFE_DEPTH];

	logic [`LIFE_ROW_BITS:0] rd_index;
	logic [`LIFE_ROW_BITS:0] wr_index;

	assign rd_index = {rd_bank, rd_addr};
	assign wr_index = {wr_bank, wr_addr};

	// Write lands at the edge
	// Read of the same word in that cycle still sees the old row
	always_ff @(posedge clk) begin
		if (we) begin
			ram[wr_index] <= wr_data;
		end
		rd_data <= ram[rd_index];
	end

	//////////////////////////////
	// Host readout
	//////////////////////////////

	// Holds the last host row until the next ld
	always_ff @(posedge clk) begin
		if (ld) begin
			dout <= rd_data;
		end
	end

endmodule

// File: hdl/life_sequencer.sv
/* Life sequencer
   Host commands, generation sweep, LFSR fill, bank select and gen counter */
`include "life_params.svh"

module life_sequencer (
	input logic clk,
	input logic reset,
	// Host commands
	input logic init_start,
	input logic step,
	input logic wr_en,
	input life_pkg::row_addr_t wr_row,
	input life_pkg::cell_row_t wr_data,
	input logic rd_req,
	input life_pkg::row_addr_t rd_row,
	// Result row from the pipe
	input life_pkg::cell_row_t row_next,
	// Host status
	output logic busy,
	output logic rd_valid,
	output life_pkg::gen_count_t gen_count,
	// Row store control
	output logic rd_bank,
	output life_pkg::row_addr_t rd_addr,
	output logic we,
	output logic wr_bank,
	output life_pkg::row_addr_t wr_addr,
	output life_pkg::cell_row_t mem_wdata,
	output logic ld,
	// Pipe window strobe
	output logic shift
);

	localparam logic [`LIFE_ROW_BITS:0] LAST_READ = `LIFE_DEPTH + 1;
	localparam logic [`LIFE_ROW_BITS:0] LAST_FILL = `LIFE_DEPTH - 1;

	life_pkg::seq_state_e state;
	// Sweep read count or fill row
	logic [`LIFE_ROW_BITS:0] idx;
	// Current bank
	logic bank;
	life_pkg::cell_row_t lfsr;

	logic idle;
	logic init_go;
	logic step_go;
	logic wr_go;
	logic rd_go;
	logic sweep_rd;
	logic fill_we;
	logic last_read;
	logic last_fill;
	logic last_write;

	// Write strobe and centre row, aligned with the pipe result
	logic [`LIFE_PIPE_LAT:0] wv;
	life_pkg::row_addr_t wa [0:`LIFE_PIPE_LAT];

	//////////////////////////////
	// Command decode
	//////////////////////////////

	assign idle = (state == life_pkg::IDLE);
	assign busy = !idle;

	// init wins over step
	assign init_go = idle && init_start;
	assign step_go = idle && step && !init_start;
	assign wr_go = idle && wr_en;
	assign rd_go = idle && rd_req;

	// First sweep read goes out in the step cycle itself
	assign sweep_rd = step_go || (state == life_pkg::SWEEP);
	assign fill_we = (state == life_pkg::FILL);
	assign last_read = (state == life_pkg::SWEEP) && (idx == LAST_READ);
	assign last_fill = fill_we && (idx == LAST_FILL);
	// Final result row leaves the delay line, nothing behind it
	assign last_write = (state == life_pkg::DRAIN) && wv[`LIFE_PIPE_LAT] &&
		!wv[`LIFE_PIPE_LAT-1];

	//////////////////////////////
	// Row store ports
	//////////////////////////////

	assign rd_bank = bank;
	// Reads DEPTH-1, 0, 1 .. DEPTH-1, 0, wrap from the truncation
	assign rd_addr = sweep_rd ? life_pkg::row_addr_t'(idx - 1'b1) : rd_row;
	assign we = wv[`LIFE_PIPE_LAT] || fill_we || wr_go;

	always_comb begin
		if (wv[`LIFE_PIPE_LAT]) begin
			// New generation into the other bank
			wr_bank = !bank;
			wr_addr = wa[`LIFE_PIPE_LAT];
			mem_wdata = row_next;
		end else if (fill_we) begin
			wr_bank = bank;
			wr_addr = life_pkg::row_addr_t'(idx);
			mem_wdata = lfsr;
		end else begin
			wr_bank = bank;
			wr_addr = wr_row;
			mem_wdata = wr_data;
		end
	end

	//////////////////////////////
	// FSM
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= life_pkg::IDLE;
			idx <= '0;
			bank <= 1'b0;
			gen_count <= '0;
			lfsr <= life_pkg::cell_row_t'(`LIFE_LFSR_SEED);
		end else begin
			case (state)
				life_pkg::IDLE: begin
					if (init_go) begin
						state <= life_pkg::FILL;
					end else if (step_go) begin
						state <= life_pkg::SWEEP;
						idx <= idx + 1'b1;
					end
				end
				life_pkg::FILL: begin
					// One LFSR step per row written, state kept across fills
					lfsr <= {lfsr[`LIFE_WIDTH-2:0],
						lfsr[`LIFE_WIDTH-1] ^ lfsr[`LIFE_LFSR_TAP]};
					if (last_fill) begin
						state <= life_pkg::IDLE;
						idx <= '0;
						gen_count <= '0;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				life_pkg::SWEEP: begin
					if (last_read) begin
						state <= life_pkg::DRAIN;
						idx <= '0;
					end else begin
						idx <= idx + 1'b1;
					end
				end
				life_pkg::DRAIN: begin
					// Swap banks as the last row lands
					if (last_write) begin
						state <= life_pkg::IDLE;
						bank <= !bank;
						gen_count <= gen_count + 1'b1;
					end
				end
				default: begin
					state <= life_pkg::IDLE;
				end
			endcase
		end
	end

	//////////////////////////////
	// Pipe timing
	//////////////////////////////

	// Shift one cycle behind each read
	// First two reads only prime the window
	always_ff @(posedge clk) begin
		if (reset) begin
			shift <= 1'b0;
			wv <= '0;
		end else begin
			shift <= sweep_rd;
			wv <= {wv[`LIFE_PIPE_LAT-1:0], sweep_rd && (idx >= 2'd2)};
		end
	end

	// Centre row is two reads behind the current one
	always_ff @(posedge clk) begin
		wa[0] <= life_pkg::row_addr_t'(idx - 2'd2);
		for (int i = 1; i <= `LIFE_PIPE_LAT; i++) begin
			wa[i] <= wa[i-1];
		end
	end

	// Host read, latch then valid
	always_ff @(posedge clk) begin
		if (reset) begin
			ld <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			ld <= rd_go;
			rd_valid <= ld;
		end
	end

endmodule

// File: testbench/tb_clock.sv
/* Testbench clock and reset
   Free running clock, synchronous reset held for the first cycles */
module tb_clock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 4
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = !clk;
		end
	end

	// Released just after an edge, like every other DUT input
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

// File: testbench/tb_life_checks.svh
/* Life reference models and compare tasks
   Toroidal generation, LFSR fill sequence and typed result checks */
`ifndef TB_LIFE_CHECKS_SVH
`define TB_LIFE_CHECKS_SVH

int error_count = 0;
int check_count = 0;

//////////////////////////////
// Reference models
//////////////////////////////

// Expected grid, one row per entry
life_pkg::cell_row_t model_grid [`LIFE_DEPTH];
// Fill LFSR as the DUT should hold it
life_pkg::cell_row_t model_lfsr = life_pkg::cell_row_t'(`LIFE_LFSR_SEED);

// Shift left, top bit xor tap bit enters at bit 0
function automatic life_pkg::cell_row_t lfsr_advance(input life_pkg::cell_row_t v);
	logic fb;
	fb = v[`LIFE_WIDTH-1] ^ v[`LIFE_LFSR_TAP];
	return (v << 1) | life_pkg::cell_row_t'(fb);
endfunction

task automatic clear_model();
	for (int r = 0; r < `LIFE_DEPTH; r++) begin
		model_grid[r] = '0;
	end
endtask

// Coordinates wrap, so shapes may straddle the edges
task automatic set_cell(input int r, input int c);
	model_grid[r % `LIFE_DEPTH][c % `LIFE_WIDTH] = 1'b1;
endtask

// One generation on the torus, eight neighbours counted
task automatic model_step();
	life_pkg::cell_row_t next_grid [`LIFE_DEPTH];
	int n;
	for (int r = 0; r < `LIFE_DEPTH; r++) begin
		for (int c = 0; c < `LIFE_WIDTH; c++) begin
			n = 0;
			for (int dr = -1; dr <= 1; dr++) begin
				for (int dc = -1; dc <= 1; dc++) begin
					if (dr != 0 || dc != 0) begin
						n += model_grid[(r + dr + `LIFE_DEPTH) % `LIFE_DEPTH]
							[(c + dc + `LIFE_WIDTH) % `LIFE_WIDTH];
					end
				end
			end
			// Birth on three, survival on two or three
			next_grid[r][c] = (n == 3) || (model_grid[r][c] && n == 2);
		end
	end
	model_grid = next_grid;
endtask

//////////////////////////////
// Compare tasks
//////////////////////////////

task automatic check_row(input string name, input life_pkg::cell_row_t got,
	input life_pkg::cell_row_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
	end
endtask

task automatic check_gen(input string name, input life_pkg::gen_count_t got,
	input life_pkg::gen_count_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
	end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
	end
endtask

// Cycle counts of busy and rd_valid
task automatic check_cycles(input string name, input int got, input int exp);
	check_count++;
	if (got != exp) begin
		error_count++;
		$display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
	end
endtask

`endif

// File: testbench/tb_life_core.sv
/* Life engine testbench
   Directed tests against software Life and LFSR models */
`include "life_params.svh"

module tb_life_core;

	localparam int STEP_BUSY = `LIFE_DEPTH + 2 + `LIFE_PIPE_LAT;
	localparam int WAIT_LIMIT = 4 * STEP_BUSY;
	localparam int READ_LIMIT = 10;

	logic clk;
	logic reset;
	logic init_start;
	logic step;
	logic wr_en;
	life_pkg::row_addr_t wr_row;
	life_pkg::cell_row_t wr_data;
	logic rd_req;
	life_pkg::row_addr_t rd_row;
	logic busy;
	logic rd_valid;
	life_pkg::cell_row_t rd_data;
	life_pkg::gen_count_t gen_count;
	int rng_start;
	// Generations expected since reset or the last fill
	life_pkg::gen_count_t model_gen;

	tb_clock #(.PERIOD(20), .RESET_CYCLES(4)) u_clock (.clk(clk), .reset(reset));

	life_core u_dut (
		.clk(clk),
		.reset(reset),
		.init_start(init_start),
		.step(step),
		.wr_en(wr_en),
		.wr_row(wr_row),
		.wr_data(wr_data),
		.rd_req(rd_req),
		.rd_row(rd_row),
		.busy(busy),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.gen_count(gen_count)
	);

	`include "tb_life_checks.svh"

	//////////////////////////////
	// Host side helpers
	//////////////////////////////

	// Drive point, just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic abort_run(input string what);
		error_count++;
		$display("Timeout at %0t: %s never happened", $time, what);
		$display("Checks %0d, errors %0d", check_count, error_count);
		$display("Something failed");
		$finish;
	endtask

	function automatic life_pkg::cell_row_t rand_row();
		life_pkg::cell_row_t v;
		v = '0;
		// 32 random bits at a time
		for (int i = 0; i < `LIFE_WIDTH; i += 32) begin
			v = (v << 32) | life_pkg::cell_row_t'($urandom());
		end
		return v;
	endfunction

	task automatic host_write(input int r, input life_pkg::cell_row_t data);
		wr_en = 1'b1;
		wr_row = life_pkg::row_addr_t'(r);
		wr_data = data;
		next_cycle();
		wr_en = 1'b0;
	endtask

	// rd_valid due two cycles after the request
	task automatic host_read(input int r, output life_pkg::cell_row_t data);
		int cycles;
		rd_req = 1'b1;
		rd_row = life_pkg::row_addr_t'(r);
		next_cycle();
		rd_req = 1'b0;
		cycles = 1;
		while (!rd_valid) begin
			if (cycles >= READ_LIMIT) begin
				abort_run("rd_valid");
			end
			next_cycle();
			cycles++;
		end
		check_cycles("rd_valid latency", cycles, 2);
		data = rd_data;
	endtask

	// Counts busy cycles, optional step pulse in the middle of them
	task automatic wait_idle(input bit poke, output int cycles);
		cycles = 0;
		while (busy) begin
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				abort_run("busy falling");
			end
			step = poke && (cycles == 3);
			next_cycle();
		end
		step = 1'b0;
	endtask

	task automatic run_step(input bit poke);
		int cycles;
		step = 1'b1;
		next_cycle();
		step = 1'b0;
		wait_idle(poke, cycles);
		model_gen = model_gen + 1'b1;
		check_cycles("step busy cycles", cycles, STEP_BUSY);
		check_gen("gen_count", gen_count, model_gen);
		// Nothing restarts behind a dropped step
		next_cycle();
		check_flag("busy", busy, 1'b0);
		check_gen("gen_count", gen_count, model_gen);
	endtask

	task automatic load_grid();
		for (int r = 0; r < `LIFE_DEPTH; r++) begin
			host_write(r, model_grid[r]);
		end
	endtask

	task automatic check_grid(input string label);
		life_pkg::cell_row_t got;
		for (int r = 0; r < `LIFE_DEPTH; r++) begin
			host_read(r, got);
			check_row($sformatf("rd_data %s row %0d", label, r), got, model_grid[r]);
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic test_reset();
		check_flag("busy", busy, 1'b0);
		check_flag("rd_valid", rd_valid, 1'b0);
		check_gen("gen_count", gen_count, '0);
	endtask

	task automatic test_write_read();
		life_pkg::cell_row_t written [`LIFE_DEPTH];
		life_pkg::cell_row_t got;
		for (int r = 0; r < `LIFE_DEPTH; r++) begin
			written[r] = rand_row();
			host_write(r, written[r]);
		end
		for (int r = 0; r < `LIFE_DEPTH; r++) begin
			host_read(r, got);
			check_row($sformatf("rd_data row %0d", r), got, written[r]);
		end
	endtask

	// Horizontal across the right edge, vertical phase across the bottom
	task automatic test_blinker();
		life_pkg::cell_row_t start [`LIFE_DEPTH];
		clear_model();
		set_cell(`LIFE_DEPTH - 1, `LIFE_WIDTH - 1);
		set_cell(`LIFE_DEPTH - 1, 0);
		set_cell(`LIFE_DEPTH - 1, 1);
		start = model_grid;
		load_grid();
		run_step(1'b0);
		model_step();
		check_grid("blinker phase");
		run_step(1'b0);
		// Period two
		model_grid = start;
		check_grid("blinker start");
	endtask

	// Moves one cell diagonally per four generations
	task automatic test_glider();
		clear_model();
		set_cell(`LIFE_DEPTH - 2, `LIFE_WIDTH - 1);
		set_cell(`LIFE_DEPTH - 1, `LIFE_WIDTH);
		set_cell(`LIFE_DEPTH, `LIFE_WIDTH - 2);
		set_cell(`LIFE_DEPTH, `LIFE_WIDTH - 1);
		set_cell(`LIFE_DEPTH, `LIFE_WIDTH);
		load_grid();
		for (int g = 1; g <= 4 * `LIFE_DEPTH; g++) begin
			run_step(1'b0);
			model_step();
			check_grid($sformatf("glider gen %0d", g));
		end
	endtask

	// Second fill picks up the LFSR where the first left it
	task automatic test_init();
		life_pkg::cell_row_t got;
		int cycles;
		for (int pass = 0; pass < 2; pass++) begin
			init_start = 1'b1;
			next_cycle();
			init_start = 1'b0;
			wait_idle(1'b0, cycles);
			model_gen = '0;
			check_cycles("fill busy cycles", cycles, `LIFE_DEPTH);
			check_gen("gen_count", gen_count, model_gen);
			for (int r = 0; r < `LIFE_DEPTH; r++) begin
				host_read(r, got);
				check_row($sformatf("rd_data fill %0d row %0d", pass, r), got, model_lfsr);
				model_lfsr = lfsr_advance(model_lfsr);
			end
		end
	endtask

	task automatic test_random_grid();
		for (int r = 0; r < `LIFE_DEPTH; r++) begin
			model_grid[r] = rand_row();
		end
		load_grid();
		for (int s = 0; s < 3; s++) begin
			// Middle step gets an extra step pulse while busy
			run_step(s == 1);
			model_step();
			check_grid($sformatf("random gen %0d", s + 1));
		end
	endtask

	//////////////////////////////
	// Run
	//////////////////////////////

	initial begin
		int cycles;
		init_start = 1'b0;
		step = 1'b0;
		wr_en = 1'b0;
		wr_row = '0;
		wr_data = '0;
		rd_req = 1'b0;
		rd_row = '0;
		model_gen = '0;
		rng_start = $urandom(32'hcbd665b1);

		// Reset sampled at the edge, where it is stable
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			if (cycles > 20) begin
				abort_run("reset release");
			end
		end while (reset);
		#1;

		test_reset();
		test_write_read();
		test_blinker();
		test_glider();
		test_init();
		test_random_grid();

		$display("Checks %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
+incdir+hdl
+incdir+testbench
hdl/life_pkg.sv
hdl/life_row_store.sv
hdl/life_cell_pipe.sv
hdl/life_sequencer.sv
hdl/life_core.sv
testbench/tb_clock.sv
testbench/tb_life_core.sv
